//--- design/uart_pkg.sv
package uart_pkg;

  // Host command with write flag, register address and write data
  typedef logic [15:0] cmd_t;
  typedef logic [7:0]  byte_t;
  typedef logic [6:0]  addr_t;

  // Line timing in clock cycles
  localparam int unsigned BIT_CYCLES    = 16;
  localparam int unsigned HALF_BIT      = BIT_CYCLES / 2;
  localparam int unsigned FRAME_BITS    = 11;
  localparam int unsigned GAP_CYCLES    = 8;
  localparam int unsigned REPLY_TIMEOUT = 40 * BIT_CYCLES;

  // Counter widths
  typedef logic [$clog2(BIT_CYCLES)-1:0]     bit_cnt_t;
  typedef logic [$clog2(FRAME_BITS+1)-1:0]   bit_idx_t;
  typedef logic [$clog2(REPLY_TIMEOUT)-1:0]  wait_cnt_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND_HDR,
    WAIT_HDR,
    GAP,
    SEND_DATA,
    WAIT_DATA,
    WAIT_REPLY,
    RESPOND
  } seq_state_t;

endpackage

//--- design/tx_byte_if.sv
interface tx_byte_if;

  uart_pkg::byte_t data;
  logic            start;
  logic            busy;
  logic            done;

  modport seq (
    output data,
    output start,
    input  busy,
    input  done
  );

  modport tx (
    input  data,
    input  start,
    output busy,
    output done
  );

endinterface

//--- design/rx_byte_if.sv
interface rx_byte_if;

  logic            enable;
  uart_pkg::byte_t data;
  logic            valid;
  logic            parity_err;

  modport seq (
    output enable,
    input  data,
    input  valid,
    input  parity_err
  );

  modport rx (
    input  enable,
    output data,
    output valid,
    output parity_err
  );

endinterface

//--- design/uart_tx.sv
module uart_tx (
  input  logic   clk,
  input  logic   rst_n,
  tx_byte_if.tx  link,
  output logic   line
);

  logic [uart_pkg::FRAME_BITS-1:0] frame_q;
  uart_pkg::bit_cnt_t              cnt;
  uart_pkg::bit_idx_t              idx;
  logic                            bit_end;

  assign bit_end = (cnt == uart_pkg::bit_cnt_t'(uart_pkg::BIT_CYCLES - 1));

  // Stop, odd parity, data LSB first, start
  always_ff @(posedge clk)
  begin
    if (link.start && !link.busy)
      frame_q <= {1'b1, ~^link.data, link.data, 1'b0};
    else if (link.busy && bit_end)
      frame_q <= {1'b1, frame_q[uart_pkg::FRAME_BITS-1:1]};
  end

  // The load cycle counts as a short lead-in before the start bit
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      link.busy <= 1'b0;
      link.done <= 1'b0;
      cnt       <= '0;
      idx       <= '0;
      line      <= 1'b1;
    end
    else
    begin
      link.done <= 1'b0;
      if (!link.busy)
      begin
        if (link.start)
        begin
          link.busy <= 1'b1;
          cnt       <= uart_pkg::bit_cnt_t'(uart_pkg::BIT_CYCLES - 1);
          idx       <= '0;
        end
      end
      else if (!bit_end)
        cnt <= cnt + 1'b1;
      else
      begin
        cnt <= '0;
        if (idx == uart_pkg::bit_idx_t'(uart_pkg::FRAME_BITS))
        begin
          // End of stop bit
          link.busy <= 1'b0;
          link.done <= 1'b1;
          line      <= 1'b1;
        end
        else
        begin
          line <= frame_q[0];
          idx  <= idx + 1'b1;
        end
      end
    end
  end

  // Sequencer must wait for the frame to finish
  assert property (@(posedge clk) disable iff (!rst_n) link.start |-> !link.busy);

endmodule

//--- design/uart_rx.sv
module uart_rx (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   line,
  rx_byte_if.rx  link
);

  logic               line_meta;
  logic               line_sync;
  logic               line_prev;
  logic               fall;
  logic               busy;
  logic               sample;
  logic               par_q;
  uart_pkg::byte_t    shift_q;
  uart_pkg::bit_cnt_t cnt;
  uart_pkg::bit_cnt_t sample_at;
  uart_pkg::bit_idx_t idx;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      line_meta <= 1'b1;
      line_sync <= 1'b1;
      line_prev <= 1'b1;
    end
    else
    begin
      line_meta <= line;
      line_sync <= line_meta;
      line_prev <= line_sync;
    end
  end

  assign fall = line_prev && !line_sync;

  // Half a bit into the start bit, then one full bit per sample
  assign sample_at = (idx == '0) ? uart_pkg::bit_cnt_t'(uart_pkg::HALF_BIT - 1)
                                 : uart_pkg::bit_cnt_t'(uart_pkg::BIT_CYCLES - 1);
  assign sample    = busy && (cnt == sample_at);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy            <= 1'b0;
      cnt             <= '0;
      idx             <= '0;
      link.valid      <= 1'b0;
      link.parity_err <= 1'b0;
    end
    else
    begin
      link.valid <= 1'b0;
      if (!busy)
      begin
        if (link.enable && fall)
        begin
          busy <= 1'b1;
          cnt  <= '0;
          idx  <= '0;
        end
      end
      else if (!sample)
        cnt <= cnt + 1'b1;
      else
      begin
        cnt <= '0;
        idx <= idx + 1'b1;
        // A glitch on the line sends the receiver back to hunting
        if (idx == '0 && line_sync)
          busy <= 1'b0;
        else if (idx == uart_pkg::bit_idx_t'(uart_pkg::FRAME_BITS - 1))
        begin
          busy            <= 1'b0;
          link.valid      <= 1'b1;
          link.parity_err <= ~(^{par_q, shift_q});
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && idx == uart_pkg::bit_idx_t'(uart_pkg::FRAME_BITS - 2))
      par_q <= line_sync;
    else if (sample && idx != '0 && idx < uart_pkg::bit_idx_t'(uart_pkg::FRAME_BITS - 2))
      shift_q <= {line_sync, shift_q[7:1]};
  end

  assign link.data = shift_q;

  assert property (@(posedge clk) disable iff (!rst_n) link.valid |=> !link.valid);

endmodule

//--- design/uart_cmd_seq.sv
module uart_cmd_seq (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::cmd_t  cmd_in,
  input  logic            cmd_vld,
  output logic            cmd_rdy,
  tx_byte_if.seq          tx_link,
  rx_byte_if.seq          rx_link,
  output uart_pkg::byte_t read_data,
  output logic            read_rdy,
  output logic            read_parity_err,
  output logic            read_timeout
);

  uart_pkg::seq_state_t state;
  uart_pkg::cmd_t       cmd_q;
  uart_pkg::addr_t      cmd_addr;
  uart_pkg::wait_cnt_t  wait_cnt;
  logic                 accept;
  logic                 got_reply;
  logic                 timed_out;

  assign cmd_rdy   = (state == uart_pkg::IDLE);
  assign accept    = cmd_vld && cmd_rdy;
  assign got_reply = (state == uart_pkg::WAIT_REPLY) && rx_link.valid;
  assign timed_out = (state == uart_pkg::WAIT_REPLY) && !rx_link.valid && (wait_cnt == '0);
  assign cmd_addr  = cmd_q[14:8];

  assign tx_link.start = (state == uart_pkg::SEND_HDR) || (state == uart_pkg::SEND_DATA);
  assign tx_link.data  = (state == uart_pkg::SEND_DATA) ? cmd_q[7:0] : {cmd_q[15], cmd_addr};
  assign rx_link.enable = (state == uart_pkg::WAIT_REPLY);
  assign read_rdy       = (state == uart_pkg::RESPOND);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state           <= uart_pkg::IDLE;
      wait_cnt        <= '0;
      read_parity_err <= 1'b0;
      read_timeout    <= 1'b0;
    end
    else
    begin
      case (state)
        uart_pkg::IDLE:
          if (cmd_vld)
            state <= uart_pkg::SEND_HDR;
        uart_pkg::SEND_HDR:
          state <= uart_pkg::WAIT_HDR;
        uart_pkg::WAIT_HDR:
          if (tx_link.done)
          begin
            if (cmd_q[15])
            begin
              // Two state steps plus two cycles of transmitter latency
              state    <= uart_pkg::GAP;
              wait_cnt <= uart_pkg::wait_cnt_t'(uart_pkg::GAP_CYCLES - 4);
            end
            else
            begin
              state    <= uart_pkg::WAIT_REPLY;
              wait_cnt <= uart_pkg::wait_cnt_t'(uart_pkg::REPLY_TIMEOUT - 1);
            end
          end
        uart_pkg::GAP:
          if (wait_cnt == '0)
            state <= uart_pkg::SEND_DATA;
          else
            wait_cnt <= wait_cnt - 1'b1;
        uart_pkg::SEND_DATA:
          state <= uart_pkg::WAIT_DATA;
        uart_pkg::WAIT_DATA:
          if (tx_link.done)
            state <= uart_pkg::IDLE;
        uart_pkg::WAIT_REPLY:
          if (got_reply || timed_out)
          begin
            state           <= uart_pkg::RESPOND;
            read_parity_err <= got_reply && rx_link.parity_err;
            read_timeout    <= timed_out;
          end
          else
            wait_cnt <= wait_cnt - 1'b1;
        default:
          state <= uart_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if (got_reply)
      read_data <= rx_link.data;
    else if (timed_out)
      read_data <= '0;
  end

  // Host sees ready only once the transmitter is quiet
  assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> !tx_link.busy);

  // Every finished frame is awaited
  assert property (@(posedge clk) disable iff (!rst_n)
    tx_link.done |-> (state == uart_pkg::WAIT_HDR || state == uart_pkg::WAIT_DATA));

endmodule

//--- design/uart_cmd_bridge.sv
module uart_cmd_bridge (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::cmd_t  cmd_in,
  input  logic            cmd_vld,
  output logic            cmd_rdy,
  input  logic            rx,
  output logic            tx,
  output uart_pkg::byte_t read_data,
  output logic            read_rdy,
  output logic            read_parity_err,
  output logic            read_timeout
);

  tx_byte_if tx_link ();
  rx_byte_if rx_link ();

  uart_cmd_seq u_seq (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_in          (cmd_in),
    .cmd_vld         (cmd_vld),
    .cmd_rdy         (cmd_rdy),
    .tx_link         (tx_link.seq),
    .rx_link         (rx_link.seq),
    .read_data       (read_data),
    .read_rdy        (read_rdy),
    .read_parity_err (read_parity_err),
    .read_timeout    (read_timeout)
  );

  // Outgoing frames
  uart_tx u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .link  (tx_link.tx),
    .line  (tx)
  );

  // Reply frames
  uart_rx u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .line  (rx),
    .link  (rx_link.rx)
  );

endmodule

//--- test/uart_peer.sv
module uart_peer (
  input  logic clk,
  input  logic tx,
  output logic rx,
  output int   bad_parity_cnt
);
  timeunit 1ns;
  timeprecision 1ps;

  // Remote register file that reads zero until written
  uart_pkg::byte_t regs [128];
  uart_pkg::byte_t hdr;
  uart_pkg::byte_t wdata;
  uart_pkg::addr_t addr;
  logic            par_ok;

  // Returns in the middle of the stop bit
  task automatic receive_frame(output uart_pkg::byte_t data, output logic odd_ok);
    logic par;
    bit   found;
    int   i;
    found = 1'b0;
    while (!found)
    begin
      @(negedge clk);
      if (tx === 1'b0)
      begin
        repeat (uart_pkg::HALF_BIT - 1) @(negedge clk);
        // Still low in mid start bit
        if (tx === 1'b0)
          found = 1'b1;
      end
    end
    for (i = 0; i < 8; i++)
    begin
      repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
      data[i] = tx;
    end
    repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
    par = tx;
    repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
    odd_ok = ^{par, data};
  endtask

  task automatic send_frame(input uart_pkg::byte_t data, input bit even_par);
    logic [uart_pkg::FRAME_BITS-1:0] bits;
    int                              i;
    bits = {1'b1, even_par ? ^data : ~^data, data, 1'b0};
    for (i = 0; i < uart_pkg::FRAME_BITS; i++)
    begin
      rx = bits[i];
      repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  initial
  begin
    int i;
    rx             = 1'b1;
    bad_parity_cnt = 0;
    for (i = 0; i < 128; i++)
      regs[i] = '0;
    forever
    begin
      receive_frame(hdr, par_ok);
      if (!par_ok)
        bad_parity_cnt++;
      addr = hdr[6:0];
      if (hdr[7])
      begin
        receive_frame(wdata, par_ok);
        if (!par_ok)
          bad_parity_cnt++;
        regs[addr] = wdata;
      end
      // Address 7e stays silent and 7f answers with even parity
      else if (addr != 7'h7e)
      begin
        repeat (3 * uart_pkg::BIT_CYCLES) @(negedge clk);
        send_frame(regs[addr], addr == 7'h7f);
      end
    end
  end

endmodule

//--- test/tb_uart_cmd_bridge.sv
module tb_uart_cmd_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned FRAME_CYCLES = uart_pkg::FRAME_BITS * uart_pkg::BIT_CYCLES;
  // Accept edge to ready covers start delay, two frames, gap and one cycle after done
  localparam int unsigned WRITE_CYCLES = 2 + 2 * FRAME_CYCLES + uart_pkg::GAP_CYCLES + 1;
  localparam int unsigned ROW_CYCLES   = 2 * FRAME_CYCLES + uart_pkg::GAP_CYCLES
                                         + uart_pkg::REPLY_TIMEOUT + 200;

  logic            clk;
  logic            rst_n;
  uart_pkg::cmd_t  cmd_in;
  logic            cmd_vld;
  logic            cmd_rdy;
  logic            rx;
  logic            tx;
  uart_pkg::byte_t read_data;
  logic            read_rdy;
  logic            read_parity_err;
  logic            read_timeout;
  int              peer_bad_parity;
  bit              table_ready;

  uart_pkg::cmd_t  row_cmd  [$];
  uart_pkg::byte_t row_data [$];
  logic            row_perr [$];
  logic            row_tmo  [$];
  uart_pkg::byte_t shadow   [128];

  uart_cmd_bridge dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_in          (cmd_in),
    .cmd_vld         (cmd_vld),
    .cmd_rdy         (cmd_rdy),
    .rx              (rx),
    .tx              (tx),
    .read_data       (read_data),
    .read_rdy        (read_rdy),
    .read_parity_err (read_parity_err),
    .read_timeout    (read_timeout)
  );

  uart_peer peer (
    .clk            (clk),
    .tx             (tx),
    .rx             (rx),
    .bad_parity_cnt (peer_bad_parity)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("** Error @ %0d ns: %s, got 'h%0h, expected 'h%0h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Expected read results follow the shadow copy of all writes so far
  task automatic add_row(input bit wr, input uart_pkg::addr_t addr);
    uart_pkg::byte_t d;
    d = uart_pkg::byte_t'($urandom);
    row_cmd.push_back({wr, addr, wr ? d : 8'h00});
    row_perr.push_back(!wr && addr == 7'h7f);
    row_tmo.push_back(!wr && addr == 7'h7e);
    if (wr)
    begin
      shadow[addr] = d;
      row_data.push_back(8'h00);
    end
    else
      row_data.push_back((addr == 7'h7e) ? 8'h00 : shadow[addr]);
  endtask

  task automatic build_table();
    int i;
    for (i = 0; i < 128; i++)
      shadow[i] = '0;
    add_row(1'b1, 7'h05);
    add_row(1'b1, 7'h3a);
    add_row(1'b1, 7'h41);
    add_row(1'b1, 7'h05);
    add_row(1'b0, 7'h05);
    add_row(1'b0, 7'h3a);
    add_row(1'b0, 7'h41);
    add_row(1'b0, 7'h12);
    add_row(1'b0, 7'h7f);
    add_row(1'b0, 7'h7e);
    add_row(1'b1, 7'h00);
    add_row(1'b0, 7'h00);
    add_row(1'b0, 7'h05);
  endtask

  // Called on a falling edge while the bridge is idle
  task automatic apply_command(input int row);
    int cycles;
    cmd_in  = row_cmd[row];
    cmd_vld = 1'b1;
    while (!cmd_rdy)
      @(negedge clk);
    @(negedge clk);
    compare_value("cmd_rdy after accept", cmd_rdy, 1'b0);
    // New command held on the bus must stay unaccepted
    cmd_in = row_cmd[row] ^ 16'h80ff;
    cycles = 0;
    if (row_cmd[row][15])
    begin
      while (!cmd_rdy)
      begin
        compare_value("read_rdy during write", read_rdy, 1'b0);
        @(negedge clk);
        cycles++;
      end
      cmd_vld = 1'b0;
      compare_value("write cycles until cmd_rdy", cycles, WRITE_CYCLES);
    end
    else
    begin
      while (!read_rdy)
      begin
        compare_value("cmd_rdy before read_rdy", cmd_rdy, 1'b0);
        @(negedge clk);
        cycles++;
      end
      compare_value("cmd_rdy with read_rdy", cmd_rdy, 1'b0);
      compare_value("read_data", read_data, row_data[row]);
      compare_value("read_parity_err", read_parity_err, row_perr[row]);
      compare_value("read_timeout", read_timeout, row_tmo[row]);
      if (row_tmo[row])
        compare_value("timeout not early", cycles >= FRAME_CYCLES + uart_pkg::REPLY_TIMEOUT,
                      1'b1);
      @(negedge clk);
      compare_value("read_rdy pulse width", read_rdy, 1'b0);
      compare_value("cmd_rdy after read_rdy", cmd_rdy, 1'b1);
      cmd_vld = 1'b0;
    end
  endtask

  initial
  begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    cmd_in      = '0;
    cmd_vld     = 1'b0;
    table_ready = 1'b0;
    void'($urandom(32'hd16a));
    build_table();
    table_ready = 1'b1;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    compare_value("tx after reset", tx, 1'b1);
    compare_value("cmd_rdy after reset", cmd_rdy, 1'b1);
    compare_value("read_rdy after reset", read_rdy, 1'b0);
    compare_value("read_parity_err after reset", read_parity_err, 1'b0);
    compare_value("read_timeout after reset", read_timeout, 1'b0);
    foreach (row_cmd[i])
      apply_command(i);
    // Odd parity on tx as seen by the remote side
    compare_value("peer parity errors", peer_bad_parity, 0);
    $display("RESULT: PASS");
    $finish;
  end

  initial
  begin
    longint limit;
    wait (table_ready);
    limit = (longint'(row_cmd.size()) * ROW_CYCLES + 20) * CLK_PERIOD;
    #(limit);
    $display("Watchdog expired after %0d ns, the run hung", limit);
    $display("RESULT: FAIL");
    $fatal(1, "Timeout");
  end

endmodule

//--- tb.f
design/uart_pkg.sv
design/tx_byte_if.sv
design/rx_byte_if.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_cmd_seq.sv
design/uart_cmd_bridge.sv
test/uart_peer.sv
test/tb_uart_cmd_bridge.sv

//--- Bender.yml
package:
  name: uart_cmd_bridge

sources:
  - files:
      - design/uart_pkg.sv
      - design/tx_byte_if.sv
      - design/rx_byte_if.sv
      - design/uart_tx.sv
      - design/uart_rx.sv
      - design/uart_cmd_seq.sv
      - design/uart_cmd_bridge.sv
  - target: test
    files:
      - test/uart_peer.sv
      - test/tb_uart_cmd_bridge.sv
